// ==== logic/udp_echo_defs.svh ====
// ****************************************
// Shared constants of the UDP echo engine
// Echo port, payload FIFO depth and
// seven-segment display geometry
// ****************************************

`ifndef UDP_ECHO_DEFS_SVH
`define UDP_ECHO_DEFS_SVH

// UDP destination port that gets echoed back
`define ECHO_PORT 16'd1234

// Payload entries buffered between filter and output
`define FIFO_DEPTH 16

// Seven-segment display
`define HEX_DIGITS 8
`define SEG_BITS 7

`endif

// ==== logic/udp_pkg.sv ====
// ****************************************
// Protocol types for the UDP echo engine
// Addresses, ports, lengths, payload bytes
// and the datagram filter states
// ****************************************

package udp_pkg;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

    // UDP length field, header plus payload
    typedef logic [15:0] udp_len_t;

    // One payload byte
    typedef logic [7:0] byte_t;

    // Datagram-level state of the port filter
    // IDLE waits for a header, FORWARD steers the
    // payload into the FIFO, DROP swallows it
    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        DROP
    } filter_state_t;

endpackage

// ==== logic/display_pkg.sv ====
// ****************************************
// Seven-segment display types and the
// nibble to segment pattern decoder
// ****************************************

`include "udp_echo_defs.svh"

package display_pkg;

    // Active-low segments, a in bit 0 up to g in bit 6
    typedef logic [`SEG_BITS-1:0] seg_t;

    typedef seg_t [`HEX_DIGITS-1:0] seg_bus_t;

    function automatic seg_t hex_to_seg(input logic [3:0] nibble);
        seg_t lit;
        // Lit segments, gfedcba
        case (nibble)
            4'h0: lit = 7'h3f;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5b;
            4'h3: lit = 7'h4f;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6d;
            4'h6: lit = 7'h7d;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7f;
            4'h9: lit = 7'h6f;
            4'ha: lit = 7'h77;
            4'hb: lit = 7'h7c;
            4'hc: lit = 7'h39;
            4'hd: lit = 7'h5e;
            4'he: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

endpackage

// ==== logic/udp_port_filter.sv ====
// ****************************************
// UDP port filter
// Matches the echo port, forms the reply
// header and steers the payload per datagram
// ****************************************

`timescale 1ns/1ns

`include "udp_echo_defs.svh"

module udp_port_filter (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_hdr_valid,
    output logic                in_hdr_ready,
    input  udp_pkg::ip_addr_t   in_src_ip,
    input  udp_pkg::ip_addr_t   in_dst_ip,
    input  udp_pkg::udp_port_t  in_src_port,
    input  udp_pkg::udp_port_t  in_dst_port,
    input  udp_pkg::udp_len_t   in_length,
    input  logic                in_valid,
    output logic                in_ready,
    input  udp_pkg::byte_t      in_data,
    input  logic                in_last,
    input  logic                in_user,
    output logic                out_hdr_valid,
    input  logic                out_hdr_ready,
    output udp_pkg::ip_addr_t   out_dst_ip,
    output udp_pkg::udp_port_t  out_src_port,
    output udp_pkg::udp_port_t  out_dst_port,
    output udp_pkg::udp_len_t   out_length,
    output logic                wr_valid,
    input  logic                wr_ready,
    output udp_pkg::byte_t      wr_data,
    output logic                wr_last,
    output logic                wr_user
);
    import udp_pkg::*;

    filter_state_t state;
    filter_state_t state_next;
    logic          port_match;
    logic          hdr_accept;
    logic          last_beat;

    assign port_match = (in_dst_port == `ECHO_PORT);

    // Reply goes back to the sender with the ports swapped
    assign out_dst_ip   = in_src_ip;
    assign out_src_port = in_dst_port;
    assign out_dst_port = in_src_port;
    assign out_length   = in_length;

    // Headers only pass between datagrams
    assign out_hdr_valid = in_hdr_valid && port_match && (state == IDLE);
    assign in_hdr_ready  = (state == IDLE) && (port_match ? out_hdr_ready : 1'b1);
    assign hdr_accept    = in_hdr_valid && in_hdr_ready;

    // Payload into the FIFO only for an echoed datagram
    assign wr_valid = in_valid && (state == FORWARD);
    assign wr_data  = in_data;
    assign wr_last  = in_last;
    assign wr_user  = in_user;

    always_comb begin
        case (state)
            FORWARD: in_ready = wr_ready;
            DROP:    in_ready = 1'b1;
            default: in_ready = 1'b0;
        endcase
    end

    assign last_beat = in_valid && in_ready && in_last;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (hdr_accept) begin
                    state_next = port_match ? FORWARD : DROP;
                end
            end
            FORWARD, DROP: begin
                if (last_beat) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== logic/payload_fifo.sv ====
// ****************************************
// Synchronous payload byte FIFO
// Stores each byte with its last and user flags
// ****************************************

`timescale 1ns/1ns

`include "udp_echo_defs.svh"

module payload_fifo #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            wr_valid,
    output logic            wr_ready,
    input  udp_pkg::byte_t  wr_data,
    input  logic            wr_last,
    input  logic            wr_user,
    output logic            rd_valid,
    input  logic            rd_ready,
    output udp_pkg::byte_t  rd_data,
    output logic            rd_last,
    output logic            rd_user
);
    import udp_pkg::*;

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    byte_t          data_mem [DEPTH];
    logic           last_mem [DEPTH];
    logic           user_mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic           do_write;
    logic           do_read;

    // Wraps at DEPTH, which need not be a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        if (ptr == AW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + AW'(1);
    endfunction

    assign wr_ready = (count != CW'(DEPTH));
    assign rd_valid = (count != '0);
    assign do_write = wr_valid && wr_ready;
    assign do_read  = rd_valid && rd_ready;

    // Head entry is visible as soon as it is counted
    assign rd_data = data_mem[rd_ptr];
    assign rd_last = last_mem[rd_ptr];
    assign rd_user = user_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            data_mem[wr_ptr] <= wr_data;
            last_mem[wr_ptr] <= wr_last;
            user_mem[wr_ptr] <= wr_user;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== logic/echo_display.sv ====
// ****************************************
// Echo status display
// First payload byte to LEDs, reply IP
// decoded onto the seven-segment digits
// ****************************************

`timescale 1ns/1ns

`include "udp_echo_defs.svh"

module echo_display (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hdr_valid,
    input  logic                   hdr_ready,
    input  udp_pkg::ip_addr_t      hdr_dst_ip,
    input  logic                   pay_valid,
    input  logic                   pay_ready,
    input  udp_pkg::byte_t         pay_data,
    input  logic                   pay_last,
    output udp_pkg::byte_t         ledg,
    output display_pkg::seg_bus_t  hex
);
    import udp_pkg::*;
    import display_pkg::*;

    logic     first_beat;
    byte_t    led_reg;
    ip_addr_t ip_reg;

    // Next beat starts a frame once the previous one carried last
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led_reg    <= '0;
            ip_reg     <= '0;
        end else begin
            if (pay_valid && pay_ready) begin
                if (first_beat) begin
                    led_reg <= pay_data;
                end
                first_beat <= pay_last;
            end
            if (hdr_valid && hdr_ready) begin
                ip_reg <= hdr_dst_ip;
            end
        end
    end

    assign ledg = led_reg;

    // Digit i shows nibble i of the reply IP
    for (genvar i = 0; i < `HEX_DIGITS; i++) begin : g_digit
        assign hex[i] = hex_to_seg(ip_reg[i*4 +: 4]);
    end

endmodule

// ==== logic/udp_echo_core.sv ====
// ****************************************
// UDP echo engine top level
// Port filter, payload FIFO and status display
// ****************************************

`timescale 1ns/1ns

`include "udp_echo_defs.svh"

module udp_echo_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_hdr_valid,
    output logic                   in_hdr_ready,
    input  udp_pkg::ip_addr_t      in_src_ip,
    input  udp_pkg::ip_addr_t      in_dst_ip,
    input  udp_pkg::udp_port_t     in_src_port,
    input  udp_pkg::udp_port_t     in_dst_port,
    input  udp_pkg::udp_len_t      in_length,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  udp_pkg::byte_t         in_data,
    input  logic                   in_last,
    input  logic                   in_user,
    output logic                   out_hdr_valid,
    input  logic                   out_hdr_ready,
    output udp_pkg::ip_addr_t      out_dst_ip,
    output udp_pkg::udp_port_t     out_src_port,
    output udp_pkg::udp_port_t     out_dst_port,
    output udp_pkg::udp_len_t      out_length,
    output logic                   out_valid,
    input  logic                   out_ready,
    output udp_pkg::byte_t         out_data,
    output logic                   out_last,
    output logic                   out_user,
    output udp_pkg::byte_t         ledg,
    output display_pkg::seg_bus_t  hex
);
    import udp_pkg::*;

    // Filter to FIFO write side
    logic  wr_valid;
    logic  wr_ready;
    byte_t wr_data;
    logic  wr_last;
    logic  wr_user;

    udp_port_filter u_filter (
        .clk           (clk),
        .rst           (rst),
        .in_hdr_valid  (in_hdr_valid),
        .in_hdr_ready  (in_hdr_ready),
        .in_src_ip     (in_src_ip),
        .in_dst_ip     (in_dst_ip),
        .in_src_port   (in_src_port),
        .in_dst_port   (in_dst_port),
        .in_length     (in_length),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_data       (in_data),
        .in_last       (in_last),
        .in_user       (in_user),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready),
        .out_dst_ip    (out_dst_ip),
        .out_src_port  (out_src_port),
        .out_dst_port  (out_dst_port),
        .out_length    (out_length),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .wr_data       (wr_data),
        .wr_last       (wr_last),
        .wr_user       (wr_user)
    );

    payload_fifo #(
        .DEPTH (`FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wr_data  (wr_data),
        .wr_last  (wr_last),
        .wr_user  (wr_user),
        .rd_valid (out_valid),
        .rd_ready (out_ready),
        .rd_data  (out_data),
        .rd_last  (out_last),
        .rd_user  (out_user)
    );

    // Display watches the output handshakes
    echo_display u_display (
        .clk        (clk),
        .rst        (rst),
        .hdr_valid  (out_hdr_valid),
        .hdr_ready  (out_hdr_ready),
        .hdr_dst_ip (out_dst_ip),
        .pay_valid  (out_valid),
        .pay_ready  (out_ready),
        .pay_data   (out_data),
        .pay_last   (out_last),
        .ledg       (ledg),
        .hex        (hex)
    );

endmodule

// ==== test/udp_echo_core_chk.sv ====
// ****************************************
// Concurrent assertions on the port filter
// and the bind that attaches them
// ****************************************

`timescale 1ns/1ns

module udp_echo_core_chk (
    input logic                    clk,
    input logic                    rst,
    input logic                    in_hdr_valid,
    input logic                    in_hdr_ready,
    input logic                    out_hdr_valid,
    input logic                    out_hdr_ready,
    input logic                    in_valid,
    input logic                    in_ready,
    input logic                    in_last,
    input udp_pkg::filter_state_t  state
);
    import udp_pkg::*;

    // Passed reply header opens an echoed payload
    a_match_forward: assert property (@(posedge clk) disable iff (rst)
        (out_hdr_valid && out_hdr_ready) |=> (state == FORWARD))
        else $error("Echoed header did not move the filter to FORWARD");

    // Header taken without a reply means the payload is discarded
    a_miss_drop: assert property (@(posedge clk) disable iff (rst)
        (in_hdr_valid && in_hdr_ready && !out_hdr_valid) |=> (state == DROP))
        else $error("Unmatched header did not move the filter to DROP");

    // Last beat closes the datagram
    a_last_idle: assert property (@(posedge clk) disable iff (rst)
        (in_valid && in_ready && in_last) |=> (state == IDLE))
        else $error("Last payload beat did not return the filter to IDLE");

endmodule

bind udp_port_filter udp_echo_core_chk u_chk (
    .clk           (clk),
    .rst           (rst),
    .in_hdr_valid  (in_hdr_valid),
    .in_hdr_ready  (in_hdr_ready),
    .out_hdr_valid (out_hdr_valid),
    .out_hdr_ready (out_hdr_ready),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_last       (in_last),
    .state         (state)
);

// ==== test/udp_echo_core_tb.sv ====
// ****************************************
// Testbench for the UDP echo engine
// Datagram table, source, sink, checks
// and watchdog
// ****************************************

`timescale 1ns/1ns

`include "udp_echo_defs.svh"

module udp_echo_core_tb;
    import udp_pkg::*;
    import display_pkg::*;

    localparam int N_DGRAMS = 8;
    localparam int MAX_PAY  = 20;

    logic       clk;
    logic       rst;
    logic       in_hdr_valid;
    logic       in_hdr_ready;
    ip_addr_t   in_src_ip;
    ip_addr_t   in_dst_ip;
    udp_port_t  in_src_port;
    udp_port_t  in_dst_port;
    udp_len_t   in_length;
    logic       in_valid;
    logic       in_ready;
    byte_t      in_data;
    logic       in_last;
    logic       in_user;
    logic       out_hdr_valid;
    logic       out_hdr_ready;
    ip_addr_t   out_dst_ip;
    udp_port_t  out_src_port;
    udp_port_t  out_dst_port;
    udp_len_t   out_length;
    logic       out_valid;
    logic       out_ready;
    byte_t      out_data;
    logic       out_last;
    logic       out_user;
    byte_t      ledg;
    seg_bus_t   hex;

    // Datagram table, three entries miss the echo port
    ip_addr_t  tbl_ip    [N_DGRAMS] = '{32'h0a000101, 32'hc0a80017, 32'hac100205,
        32'h0a0a0a0a, 32'hc0a8010a, 32'h08080808, 32'h7f000001, 32'hdeadbeef};
    udp_port_t tbl_sport [N_DGRAMS] = '{16'd5000, 16'd40000, 16'd6001, 16'd7000,
        16'd5353, 16'd61000, 16'd1111, 16'd65535};
    udp_port_t tbl_dport [N_DGRAMS] = '{`ECHO_PORT, 16'd80, `ECHO_PORT, `ECHO_PORT,
        16'd53, `ECHO_PORT, 16'd1235, `ECHO_PORT};
    int        tbl_len   [N_DGRAMS] = '{4, 7, 20, 1, 12, 9, 3, 16};

    // Active-low digit patterns 0 to F, gfedcba
    seg_t seg_low [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

    byte_t     pay_data [N_DGRAMS][MAX_PAY];
    logic      pay_user [N_DGRAMS][MAX_PAY];
    ip_addr_t  exp_ip    [$];
    udp_port_t exp_sport [$];
    udp_port_t exp_dport [$];
    udp_len_t  exp_len   [$];
    byte_t     exp_data  [$];
    logic      exp_last  [$];
    logic      exp_user  [$];
    byte_t     exp_first [$];

    integer    seed = 18;
    logic      checking = 1'b0;
    logic      led_pending = 1'b0;
    logic      hex_pending = 1'b0;
    byte_t     led_expect;
    ip_addr_t  hex_expect;

    udp_echo_core u_udp_echo_core (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_ip(input string name, input ip_addr_t got, input ip_addr_t want);
        if (got !== want) begin
            fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_port(input string name, input udp_port_t got, input udp_port_t want);
        if (got !== want) begin
            fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_len(input string name, input udp_len_t got, input udp_len_t want);
        if (got !== want) begin
            fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t want);
        if (got !== want) begin
            fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_seg(input string name, input seg_t got, input seg_t want);
        if (got !== want) begin
            fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    function automatic seg_t expected_seg(input logic [3:0] nibble);
        return seg_low[nibble];
    endfunction

    task automatic check_digits(input ip_addr_t ip);
        for (int i = 0; i < `HEX_DIGITS; i++) begin
            check_seg($sformatf("hex[%0d]", i), hex[i], expected_seg(ip[i*4 +: 4]));
        end
    endtask

    // Random payloads, and the echo rule applied to every datagram
    task automatic build_expected();
        for (int k = 0; k < N_DGRAMS; k++) begin
            if (tbl_dport[k] == `ECHO_PORT) begin
                exp_ip.push_back(tbl_ip[k]);
                exp_sport.push_back(tbl_dport[k]);
                exp_dport.push_back(tbl_sport[k]);
                exp_len.push_back(udp_len_t'(tbl_len[k] + 8));
            end
            for (int j = 0; j < tbl_len[k]; j++) begin
                pay_data[k][j] = byte_t'($random(seed));
                pay_user[k][j] = 1'($random(seed));
                if (tbl_dport[k] == `ECHO_PORT) begin
                    exp_data.push_back(pay_data[k][j]);
                    exp_last.push_back(j == tbl_len[k] - 1);
                    exp_user.push_back(pay_user[k][j]);
                end
            end
            if (tbl_dport[k] == `ECHO_PORT) begin
                exp_first.push_back(pay_data[k][0]);
            end
        end
    endtask

    task automatic send_header(input int k);
        @(negedge clk);
        in_valid     = 1'b0;
        in_hdr_valid = 1'b1;
        in_src_ip    = tbl_ip[k];
        in_src_port  = tbl_sport[k];
        in_dst_port  = tbl_dport[k];
        in_length    = udp_len_t'(tbl_len[k] + 8);
        #1;
        while (!in_hdr_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
    endtask

    task automatic send_payload(input int k);
        for (int j = 0; j < tbl_len[k]; j++) begin
            @(negedge clk);
            in_hdr_valid = 1'b0;
            in_valid     = 1'b1;
            in_data      = pay_data[k][j];
            in_last      = (j == tbl_len[k] - 1);
            in_user      = pay_user[k][j];
            #1;
            while (!in_ready) begin
                @(negedge clk);
                #1;
            end
            @(posedge clk);
        end
    endtask

    // Output sink with random back-pressure on both channels
    initial begin : sink
        forever begin
            @(negedge clk);
            out_ready     = (($random(seed) & 3) != 0);
            out_hdr_ready = (($random(seed) & 3) != 0);
        end
    end

    // Handshakes sampled late in the low phase, stable up to the next rising edge
    initial begin : monitor
        forever begin
            @(negedge clk);
            #1;
            if (checking) begin
                if (hex_pending) begin
                    check_digits(hex_expect);
                    hex_pending = 1'b0;
                end
                if (led_pending) begin
                    check_byte("ledg", ledg, led_expect);
                    led_pending = 1'b0;
                end
                if (out_hdr_valid && out_hdr_ready) begin
                    if (exp_ip.size() == 0) begin
                        fail_run("An output header appeared that no echoed datagram explains");
                    end
                    hex_expect = exp_ip.pop_front();
                    check_ip("out_dst_ip", out_dst_ip, hex_expect);
                    check_port("out_src_port", out_src_port, exp_sport.pop_front());
                    check_port("out_dst_port", out_dst_port, exp_dport.pop_front());
                    check_len("out_length", out_length, exp_len.pop_front());
                    hex_pending = 1'b1;
                end
                if (out_valid && out_ready) begin
                    if (exp_data.size() == 0) begin
                        fail_run("A payload byte came out after all echo data was received");
                    end
                    check_byte("out_data", out_data, exp_data.pop_front());
                    check_bit("out_last", out_last, exp_last.pop_front());
                    check_bit("out_user", out_user, exp_user.pop_front());
                    if (out_last) begin
                        led_expect  = exp_first.pop_front();
                        led_pending = 1'b1;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        int total;
        total = 0;
        for (int k = 0; k < N_DGRAMS; k++) begin
            total += tbl_len[k];
        end
        repeat (200 * total + 200) @(posedge clk);
        fail_run("Timeout: the echo traffic did not drain in time");
    end

    initial begin : main
        rst           = 1'b1;
        in_hdr_valid  = 1'b0;
        in_src_ip     = '0;
        in_dst_ip     = 32'hc0a80164;
        in_src_port   = '0;
        in_dst_port   = '0;
        in_length     = '0;
        in_valid      = 1'b0;
        in_data       = '0;
        in_last       = 1'b0;
        in_user       = 1'b0;
        out_hdr_ready = 1'b0;
        out_ready     = 1'b0;
        build_expected();

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("out_hdr_valid", out_hdr_valid, 1'b0);
        check_byte("ledg", ledg, 8'h00);
        check_digits('0);
        checking = 1'b1;

        for (int k = 0; k < N_DGRAMS; k++) begin
            send_header(k);
            send_payload(k);
        end
        @(negedge clk);
        in_valid = 1'b0;

        while (exp_data.size() != 0 || exp_ip.size() != 0 || led_pending || hex_pending) begin
            @(posedge clk);
        end
        @(negedge clk);
        #2;
        // Dropped payloads must not linger in the FIFO
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("out_hdr_valid", out_hdr_valid, 1'b0);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+logic
logic/udp_pkg.sv
logic/display_pkg.sv
logic/udp_port_filter.sv
logic/payload_fifo.sv
logic/echo_display.sv
logic/udp_echo_core.sv
test/udp_echo_core_chk.sv
test/udp_echo_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the UDP echo engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module udp_echo_core_tb \
    --Mdir obj_dir \
    -o udp_echo_core_sim

./obj_dir/udp_echo_core_sim
